/* xcvr_drp_params.svh */
/* Build-time constants of the transceiver DRP access path.
   Included by the package and by every module that sizes or compares
   against one of these values. */

`ifndef XCVR_DRP_PARAMS_SVH
`define XCVR_DRP_PARAMS_SVH

// Number of lanes on the read-back chain, which may be anything from 1 to 254
`define XCVR_NUM_LANES    4

// DRP address width, which gives each lane 16 registers
`define XCVR_DRP_AW       4

// DRP data width
`define XCVR_DRP_DW       16

// Select value that addresses every lane at once
`define XCVR_SEL_ALL      8'hff

// Cycles the controller waits for a chain ready after the enable pulse
`define XCVR_DRP_TIMEOUT  32

`endif

/* xcvr_drp_pkg.sv */
/* Types shared by the DRP controller, the lanes and the read-back chain.
   Modules import it inside their body and use scoped names on ports. */

`include "xcvr_drp_params.svh"

package xcvr_drp_pkg;

  // DRP register address inside one lane
  typedef logic [`XCVR_DRP_AW-1:0] drp_addr_t;

  // DRP data word, as written and as read back
  typedef logic [`XCVR_DRP_DW-1:0] drp_data_t;

  // Lane select: a lane index, the broadcast value, or anything else for no lane
  typedef logic [7:0] lane_sel_t;

  // Controller FSM states
  // IDLE waits for a request, ACCESS is the enable cycle,
  // WAIT counts down for ready and DONE is the acknowledge cycle
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT,
    DONE
  } ctrl_state_t;

endpackage

/* xcvr_drp_ctrl.sv */
/* Register-side controller of the DRP path. Takes one request at a time,
   pulses the lane enable, then waits for the read-back chain or a timeout
   and returns a single acknowledge with the read data and an error flag. */

`timescale 1ns/100ps
`include "xcvr_drp_params.svh"

module xcvr_drp_ctrl (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  logic                    up_req_i,
  input  xcvr_drp_pkg::lane_sel_t up_sel_i,
  input  xcvr_drp_pkg::drp_addr_t up_addr_i,
  input  logic                    up_wr_i,
  input  xcvr_drp_pkg::drp_data_t up_wdata_i,
  input  xcvr_drp_pkg::drp_data_t up_chain_rdata_i,
  input  logic                    up_chain_ready_i,
  output logic                    up_enb_o,
  output xcvr_drp_pkg::lane_sel_t up_sel_o,
  output xcvr_drp_pkg::drp_addr_t up_addr_o,
  output logic                    up_wr_o,
  output xcvr_drp_pkg::drp_data_t up_wdata_o,
  output logic                    up_busy_o,
  output logic                    up_ack_o,
  output xcvr_drp_pkg::drp_data_t up_rdata_o,
  output logic                    up_err_o
);

  import xcvr_drp_pkg::*;

  // Wide enough to hold the full timeout count
  localparam int TMR_W = $clog2(`XCVR_DRP_TIMEOUT + 1);

  ctrl_state_t      state;
  logic [TMR_W-1:0] timer;

  // ************************************************************************
  // Request FSM
  // ************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state      <= IDLE;
      timer      <= '0;
      up_enb_o   <= 1'b0;
      up_sel_o   <= '0;
      up_addr_o  <= '0;
      up_wr_o    <= 1'b0;
      up_wdata_o <= '0;
      up_busy_o  <= 1'b0;
      up_ack_o   <= 1'b0;
      up_rdata_o <= '0;
      up_err_o   <= 1'b0;
    end else begin
      // Enable and acknowledge are single-cycle pulses
      up_enb_o <= 1'b0;
      up_ack_o <= 1'b0;

      case (state)
        IDLE: begin
          // Busy is low here, so a strobe is always accepted in this state
          if (up_req_i) begin
            up_sel_o   <= up_sel_i;
            up_addr_o  <= up_addr_i;
            up_wr_o    <= up_wr_i;
            up_wdata_o <= up_wdata_i;
            up_busy_o  <= 1'b1;
            up_enb_o   <= 1'b1;
            state      <= ACCESS;
          end
        end

        ACCESS: begin
          // The enable is high during this cycle; the countdown starts after it
          timer <= TMR_W'(`XCVR_DRP_TIMEOUT - 1);
          state <= WAIT;
        end

        WAIT: begin
          if (up_chain_ready_i) begin
            up_rdata_o <= up_chain_rdata_i;
            up_err_o   <= 1'b0;
            up_ack_o   <= 1'b1;
            state      <= DONE;
          end else if (timer == '0) begin
            // No lane answered the select
            up_rdata_o <= '0;
            up_err_o   <= 1'b1;
            up_ack_o   <= 1'b1;
            state      <= DONE;
          end else begin
            timer <= timer - 1'b1;
          end
        end

        DONE: begin
          // Busy stays up through the ack cycle so a strobe here is dropped
          up_busy_o <= 1'b0;
          state     <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* xcvr_lane_drp.sv */
/* Behavioural stand-in for one transceiver lane's DRP port. Holds a small
   register file and answers a selected access after LANE_ID+1 cycles with a
   one-cycle ready pulse and the read data. */

`timescale 1ns/100ps
`include "xcvr_drp_params.svh"

module xcvr_lane_drp #(
  parameter int LANE_ID = 0
) (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  logic                    up_enb_i,
  input  xcvr_drp_pkg::lane_sel_t up_sel_i,
  input  xcvr_drp_pkg::drp_addr_t up_addr_i,
  input  logic                    up_wr_i,
  input  xcvr_drp_pkg::drp_data_t up_wdata_i,
  output xcvr_drp_pkg::drp_data_t up_rdata_o,
  output logic                    up_ready_o
);

  import xcvr_drp_pkg::*;

  localparam int NUM_REGS = 2 ** `XCVR_DRP_AW;

  drp_data_t  regfile [NUM_REGS];
  logic [7:0] cnt;
  logic       sel_hit;
  logic       go;

  // The lane answers its own index and the broadcast select
  assign sel_hit = (up_sel_i == lane_sel_t'(LANE_ID)) || (up_sel_i == `XCVR_SEL_ALL);

  // Lane 0 acts on the enable edge itself, the others when the count reaches one
  assign go = up_enb_i ? (sel_hit && (LANE_ID == 0)) : (cnt == 8'd1);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      cnt        <= 8'd0;
      up_ready_o <= 1'b0;
      up_rdata_o <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regfile[i] <= '0;
      end
    end else begin
      // Port latency model, counting down from the lane index
      if (up_enb_i) begin
        cnt <= sel_hit ? 8'(LANE_ID) : 8'd0;
      end else if (cnt != 8'd0) begin
        cnt <= cnt - 8'd1;
      end

      up_ready_o <= go;
      if (go) begin
        if (up_wr_i) begin
          regfile[up_addr_i] <= up_wdata_i;
          // A write answers with zero data
          up_rdata_o <= '0;
        end else begin
          up_rdata_o <= regfile[up_addr_i];
        end
      end
    end
  end

endmodule

/* xcvr_drp_chain.sv */
/* One stage of the lane read-back daisy chain. Forwards the upstream result,
   substitutes its own lane's answer, or under broadcast waits for both and
   merges them into a single ready pulse. Each stage adds one register. */

`timescale 1ns/100ps
`include "xcvr_drp_params.svh"

module xcvr_drp_chain #(
  parameter int LANE_ID = 0
) (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  xcvr_drp_pkg::lane_sel_t up_sel_i,
  input  logic                    up_enb_i,
  input  xcvr_drp_pkg::drp_data_t up_rdata_in_i,
  input  logic                    up_ready_in_i,
  input  xcvr_drp_pkg::drp_data_t up_rdata_i,
  input  logic                    up_ready_i,
  output xcvr_drp_pkg::drp_data_t up_rdata_out_o,
  output logic                    up_ready_out_o
);

  import xcvr_drp_pkg::*;

  // The first stage has nobody upstream, so its upstream latch counts as set
  localparam bit FIRST_STAGE = (LANE_ID == 0);

  drp_data_t up_rdata_up;
  logic      up_ready_up;
  drp_data_t up_rdata_lc;
  logic      up_ready_lc;
  logic      up_ready_mg_d;
  drp_data_t up_rdata_mg;
  logic      up_ready_mg;

  // Broadcast merge of the two latched results
  assign up_rdata_mg = up_rdata_up | up_rdata_lc;
  assign up_ready_mg = up_ready_up & up_ready_lc;

  // ************************************************************************
  // Output select
  // ************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rdata_out_o <= '0;
      up_ready_out_o <= 1'b0;
    end else begin
      case (up_sel_i)
        `XCVR_SEL_ALL: begin
          up_rdata_out_o <= up_rdata_mg;
          // Only the rising edge of the merged ready goes downstream
          up_ready_out_o <= up_ready_mg & ~up_ready_mg_d;
        end
        lane_sel_t'(LANE_ID): begin
          up_rdata_out_o <= up_rdata_i;
          up_ready_out_o <= up_ready_i;
        end
        default: begin
          up_rdata_out_o <= up_rdata_in_i;
          up_ready_out_o <= up_ready_in_i;
        end
      endcase
    end
  end

  // Delayed merged ready for the edge detect
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_ready_mg_d <= 1'b0;
    end else begin
      up_ready_mg_d <= up_ready_mg;
    end
  end

  // ************************************************************************
  // Result latches, cleared by the enable of each new access
  // ************************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rdata_up <= '0;
      up_ready_up <= 1'b0;
    end else if (up_ready_in_i || FIRST_STAGE) begin
      up_rdata_up <= up_rdata_in_i;
      up_ready_up <= 1'b1;
    end else if (up_enb_i) begin
      up_rdata_up <= '0;
      up_ready_up <= 1'b0;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rdata_lc <= '0;
      up_ready_lc <= 1'b0;
    end else if (up_ready_i) begin
      up_rdata_lc <= up_rdata_i;
      up_ready_lc <= 1'b1;
    end else if (up_enb_i) begin
      up_rdata_lc <= '0;
      up_ready_lc <= 1'b0;
    end
  end

endmodule

/* xcvr_drp_top.sv */
/* Top of the DRP access path: the register-side controller, one DRP model
   per lane and the read-back chain that joins the lanes back together. */

`timescale 1ns/100ps
`include "xcvr_drp_params.svh"

module xcvr_drp_top (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  logic                    up_req_i,
  input  xcvr_drp_pkg::lane_sel_t up_sel_i,
  input  xcvr_drp_pkg::drp_addr_t up_addr_i,
  input  logic                    up_wr_i,
  input  xcvr_drp_pkg::drp_data_t up_wdata_i,
  output logic                    up_busy_o,
  output logic                    up_ack_o,
  output xcvr_drp_pkg::drp_data_t up_rdata_o,
  output logic                    up_err_o
);

  import xcvr_drp_pkg::*;

  localparam int NL = `XCVR_NUM_LANES;

  // Request fields shared by every lane and chain stage
  logic      up_enb;
  lane_sel_t up_sel;
  drp_addr_t up_addr;
  logic      up_wr;
  drp_data_t up_wdata;

  // Lane answers, one per lane
  drp_data_t up_lane_rdata [NL];
  logic      up_lane_ready [NL];

  // Chain links; entry k feeds stage k and entry NL goes to the controller
  drp_data_t up_chain_rdata [NL+1];
  logic      up_chain_ready [NL+1];

  assign up_chain_rdata[0] = '0;
  assign up_chain_ready[0] = 1'b0;

  xcvr_drp_ctrl i_ctrl (
    .up_clk           (up_clk),
    .up_rstn          (up_rstn),
    .up_req_i         (up_req_i),
    .up_sel_i         (up_sel_i),
    .up_addr_i        (up_addr_i),
    .up_wr_i          (up_wr_i),
    .up_wdata_i       (up_wdata_i),
    .up_chain_rdata_i (up_chain_rdata[NL]),
    .up_chain_ready_i (up_chain_ready[NL]),
    .up_enb_o         (up_enb),
    .up_sel_o         (up_sel),
    .up_addr_o        (up_addr),
    .up_wr_o          (up_wr),
    .up_wdata_o       (up_wdata),
    .up_busy_o        (up_busy_o),
    .up_ack_o         (up_ack_o),
    .up_rdata_o       (up_rdata_o),
    .up_err_o         (up_err_o)
  );

  for (genvar k = 0; k < NL; k++) begin : g_lane
    xcvr_lane_drp #(.LANE_ID(k)) i_lane (
      .up_clk     (up_clk),
      .up_rstn    (up_rstn),
      .up_enb_i   (up_enb),
      .up_sel_i   (up_sel),
      .up_addr_i  (up_addr),
      .up_wr_i    (up_wr),
      .up_wdata_i (up_wdata),
      .up_rdata_o (up_lane_rdata[k]),
      .up_ready_o (up_lane_ready[k])
    );

    xcvr_drp_chain #(.LANE_ID(k)) i_chain (
      .up_clk         (up_clk),
      .up_rstn        (up_rstn),
      .up_sel_i       (up_sel),
      .up_enb_i       (up_enb),
      .up_rdata_in_i  (up_chain_rdata[k]),
      .up_ready_in_i  (up_chain_ready[k]),
      .up_rdata_i     (up_lane_rdata[k]),
      .up_ready_i     (up_lane_ready[k]),
      .up_rdata_out_o (up_chain_rdata[k+1]),
      .up_ready_out_o (up_chain_ready[k+1])
    );
  end

endmodule

/* tb_xcvr_drp.sv */
/* Testbench for the DRP access path. Drives register requests into
   xcvr_drp_top, keeps its own model of every lane's register file and checks
   each acknowledge against it with immediate assertions. */

`timescale 1ns/100ps
`include "xcvr_drp_params.svh"

module tb_xcvr_drp;

  import xcvr_drp_pkg::*;

  localparam int NL        = `XCVR_NUM_LANES;
  localparam int NUM_REGS  = 2 ** `XCVR_DRP_AW;
  // Longest legal wait for an ack, with margin for the chain and the lanes
  localparam int ACK_LIMIT = `XCVR_DRP_TIMEOUT + 4 * NL + 8;

  logic      up_clk;
  logic      up_rstn;
  logic      up_req_i;
  lane_sel_t up_sel_i;
  drp_addr_t up_addr_i;
  logic      up_wr_i;
  drp_data_t up_wdata_i;
  logic      up_busy_o;
  logic      up_ack_o;
  drp_data_t up_rdata_o;
  logic      up_err_o;

  // Reference register file of every lane
  drp_data_t   model [NL][NUM_REGS];
  logic [15:0] lfsr_state = 16'd39856;
  int          errors = 0;
  int          timeouts = 0;

  xcvr_drp_top i_dut (.*);

  initial begin
    up_clk = 1'b0;
    forever #20 up_clk = ~up_clk;
  end

  // ************************************************************************
  // Stimulus and reference helpers
  // ************************************************************************

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step for every bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[14:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // A lane index or the broadcast value gets an answer, nothing else does
  function automatic logic sel_answered(input lane_sel_t sel);
    return (sel == `XCVR_SEL_ALL) || (int'(sel) < NL);
  endfunction

  // Writes read back zero and a broadcast read is the OR over all lanes
  function automatic drp_data_t expected_rdata(input lane_sel_t sel, input drp_addr_t addr,
                                               input logic wr);
    drp_data_t acc;
    acc = '0;
    if (!wr && sel == `XCVR_SEL_ALL) begin
      for (int k = 0; k < NL; k++) begin
        acc |= model[k][addr];
      end
    end else if (!wr && int'(sel) < NL) begin
      acc = model[int'(sel)][addr];
    end
    return acc;
  endfunction

  task automatic update_model(input lane_sel_t sel, input drp_addr_t addr, input drp_data_t d);
    for (int k = 0; k < NL; k++) begin
      if (sel == `XCVR_SEL_ALL || int'(sel) == k) begin
        model[k][addr] = d;
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("CHECK FAILED at %0t ns: %s expected 'h%0h, got 'h%0h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  // ************************************************************************
  // Bus tasks
  // ************************************************************************

  // One-cycle request strobe with its fields
  task automatic send_request(input lane_sel_t sel, input drp_addr_t addr, input logic wr,
                              input drp_data_t wdata);
    @(posedge up_clk);
    up_req_i   <= 1'b1;
    up_sel_i   <= sel;
    up_addr_i  <= addr;
    up_wr_i    <= wr;
    up_wdata_i <= wdata;
    @(posedge up_clk);
    up_req_i <= 1'b0;
  endtask

  // Acknowledge is sampled on the falling edge, away from the register updates
  task automatic wait_ack(output drp_data_t rdata, output logic err, output logic got);
    int waited;
    waited = 0;
    got    = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    do begin
      @(negedge up_clk);
      waited++;
      got = up_ack_o;
    end while (!got && waited < ACK_LIMIT);
    if (got) begin
      rdata = up_rdata_o;
      err   = up_err_o;
    end else begin
      $display("Timeout at %0t ns: no acknowledge within %0d cycles", $time, ACK_LIMIT);
      timeouts++;
    end
  endtask

  task automatic check_access(input lane_sel_t sel, input drp_addr_t addr, input logic wr,
                              input drp_data_t wdata);
    drp_data_t exp_data;
    drp_data_t rdata;
    logic      err;
    logic      got;
    exp_data = expected_rdata(sel, addr, wr);
    send_request(sel, addr, wr, wdata);
    wait_ack(rdata, err, got);
    if (got) begin
      compare_value("up_rdata_o", 32'(exp_data), 32'(rdata));
      compare_value("up_err_o", 32'(!sel_answered(sel)), 32'(err));
    end
    // Only an answered write reaches a register file
    if (wr && sel_answered(sel)) begin
      update_model(sel, addr, wdata);
    end
  endtask

  // The ack is a single pulse, so none may follow for a while
  task automatic expect_no_ack(input int cycles);
    repeat (cycles) begin
      @(negedge up_clk);
      assert (!up_ack_o) else begin
        $display("Unexpected second acknowledge at %0t ns", $time);
        errors++;
      end
    end
  endtask

  // ************************************************************************
  // Test sequence
  // ************************************************************************

  initial begin
    drp_addr_t used_addr [4];
    drp_addr_t a;
    drp_data_t d;
    int        waited;

    up_rstn    = 1'b0;
    up_req_i   = 1'b0;
    up_sel_i   = '0;
    up_addr_i  = '0;
    up_wr_i    = 1'b0;
    up_wdata_i = '0;
    for (int k = 0; k < NL; k++) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        model[k][r] = '0;
      end
    end

    // Reset for five rising edges, with the outputs checked while it is low
    for (int i = 0; i < 5; i++) begin
      @(posedge up_clk);
      if (i == 4) begin
        up_rstn <= 1'b1;
      end
      @(negedge up_clk);
      compare_value("up_busy_o", 32'(0), 32'(up_busy_o));
      compare_value("up_ack_o", 32'(0), 32'(up_ack_o));
    end
    repeat (2) begin
      @(negedge up_clk);
      compare_value("up_busy_o", 32'(0), 32'(up_busy_o));
      compare_value("up_ack_o", 32'(0), 32'(up_ack_o));
    end

    // First reads after reset come back zero from every lane
    for (int k = 0; k < NL; k++) begin
      check_access(lane_sel_t'(k), drp_addr_t'(rand_bits(`XCVR_DRP_AW)), 1'b0, '0);
    end

    // Single-lane writes and read-back, then a sweep over all lanes
    for (int k = 0; k < NL; k++) begin
      for (int j = 0; j < 4; j++) begin
        used_addr[j] = drp_addr_t'(rand_bits(`XCVR_DRP_AW));
        d = drp_data_t'(rand_bits(`XCVR_DRP_DW));
        check_access(lane_sel_t'(k), used_addr[j], 1'b1, d);
      end
      for (int m = 0; m < NL; m++) begin
        for (int j = 0; j < 4; j++) begin
          check_access(lane_sel_t'(m), used_addr[j], 1'b0, '0);
        end
      end
    end

    // Broadcast write lands in every lane
    a = drp_addr_t'(rand_bits(`XCVR_DRP_AW));
    d = drp_data_t'(rand_bits(`XCVR_DRP_DW));
    check_access(`XCVR_SEL_ALL, a, 1'b1, d);
    for (int k = 0; k < NL; k++) begin
      check_access(lane_sel_t'(k), a, 1'b0, '0);
    end

    // Distinct values per lane because the low nibble carries the lane index
    a = drp_addr_t'(rand_bits(`XCVR_DRP_AW));
    for (int k = 0; k < NL; k++) begin
      d = {drp_data_t'(rand_bits(12)) << 4} | drp_data_t'(k & 15);
      check_access(lane_sel_t'(k), a, 1'b1, d);
    end
    check_access(`XCVR_SEL_ALL, a, 1'b0, '0);
    expect_no_ack(4 * NL + 8);

    // Selects that no lane answers, then proof that no lane was written
    a = drp_addr_t'(rand_bits(`XCVR_DRP_AW));
    check_access(lane_sel_t'(NL), a, 1'b1, drp_data_t'(rand_bits(`XCVR_DRP_DW)));
    check_access(8'h80, a, 1'b1, drp_data_t'(rand_bits(`XCVR_DRP_DW)));
    for (int k = 0; k < NL; k++) begin
      check_access(lane_sel_t'(k), a, 1'b0, '0);
    end

    // A strobe while busy is dropped and must not write lane 0
    send_request(lane_sel_t'(NL), a, 1'b1, 16'h1234);
    waited = 0;
    do begin
      @(negedge up_clk);
      waited++;
    end while (!up_busy_o && waited < 8);
    if (!up_busy_o) begin
      $display("Timeout at %0t ns: busy never rose after an accepted request", $time);
      timeouts++;
    end
    send_request(8'h00, a, 1'b1, drp_data_t'(rand_bits(`XCVR_DRP_DW)) | 16'h0001);
    begin
      drp_data_t rdata;
      logic      err;
      logic      got;
      wait_ack(rdata, err, got);
      if (got) begin
        compare_value("up_rdata_o", 32'(0), 32'(rdata));
        compare_value("up_err_o", 32'(1), 32'(err));
      end
    end
    expect_no_ack(`XCVR_DRP_TIMEOUT + 4 * NL + 8);
    check_access(8'h00, a, 1'b0, '0);

    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
xcvr_drp_pkg.sv
xcvr_drp_ctrl.sv
xcvr_lane_drp.sv
xcvr_drp_chain.sv
xcvr_drp_top.sv
tb_xcvr_drp.sv

/* run_sim.sh */
#!/bin/sh
# Build the DRP testbench with Verilator and run it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_xcvr_drp \
  -Mdir obj_dir

./obj_dir/Vtb_xcvr_drp > sim.log 2>&1
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
